// ==== filelist.f ====
+incdir+rtl
+incdir+test
rtl/ingress_pkg.sv
rtl/tlp_rx_ctrl.sv
rtl/ctrl_reg_decoder.sv
rtl/cpl_buffer_writer.sv
rtl/pcie_ingress.sv
test/tb_pcie_ingress.sv

// ==== rtl/cpl_buffer_writer.sv ====
// Completion buffer writer
// Places CplD payload dwords in the buffer and reports each finished completion
`timescale 1ns/1ps
`include "ingress_params.svh"

module cpl_buffer_writer (
  input  logic                     clk,
  input  logic                     rst,
  input  logic                     i_cpl_start,
  input  logic                     i_cpl_beat_stb,
  input  logic [`DW_W-1:0]         i_cpl_data,
  input  logic [`DW_W-1:0]         i_hdr_dw0,
  input  logic [`DW_W-1:0]         i_hdr_dw1,
  input  ingress_pkg::tlp_dw2_u    i_hdr_dw2,
  input  logic [`BUF_OFFSET_W-1:0] i_buf_offset,
  output logic                     o_buf_we,
  output logic [`BUF_ADDR_W-1:0]   o_buf_addr,
  output logic [`DW_W-1:0]         o_buf_data,
  output logic                     o_cplt_pkt_stb,
  output logic [9:0]               o_cplt_pkt_cnt,
  output logic [7:0]               o_cplt_pkt_tag,
  output logic [11:0]              o_cplt_pkt_byte_count,
  output logic [6:0]               o_cplt_pkt_lwr_addr
);

  logic [`BUF_OFFSET_W-1:0] base_addr;
  logic [`BUF_ADDR_W-1:0]   wr_ptr;
  logic [9:0]               dw_cnt;
  logic                     take_beat;

  // Start of this completion within the buffer
  assign base_addr = i_buf_offset - `BUF_OFFSET_W'(i_hdr_dw2.cpl.lwr_addr);
  // Beats past the length field are dropped
  assign take_beat = i_cpl_beat_stb && (dw_cnt != o_cplt_pkt_cnt);

  always_ff @(posedge clk) begin
    if (rst) begin
      o_buf_we              <= 1'b0;
      o_cplt_pkt_stb        <= 1'b0;
      dw_cnt                <= '0;
      o_cplt_pkt_cnt        <= '0;
      o_cplt_pkt_tag        <= '0;
      o_cplt_pkt_byte_count <= '0;
      o_cplt_pkt_lwr_addr   <= '0;
    end else begin
      o_buf_we       <= take_beat;
      // Count already reached the length when the final dword was written
      o_cplt_pkt_stb <= o_buf_we && (dw_cnt == o_cplt_pkt_cnt);
      if (i_cpl_start) begin
        dw_cnt                <= '0;
        o_cplt_pkt_cnt        <= i_hdr_dw0[`TLP_LEN_HI:`TLP_LEN_LO];
        o_cplt_pkt_tag        <= i_hdr_dw2.cpl.tag;
        o_cplt_pkt_byte_count <= i_hdr_dw1[`CPL_BYTE_CNT_HI:`CPL_BYTE_CNT_LO];
        o_cplt_pkt_lwr_addr   <= i_hdr_dw2.cpl.lwr_addr;
      end else if (take_beat) begin
        dw_cnt <= dw_cnt + 10'd1;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (i_cpl_start) begin
      wr_ptr <= base_addr[`BUF_ADDR_W-1:0];
    end else if (take_beat) begin
      wr_ptr <= wr_ptr + `BUF_ADDR_W'(1);
    end
    if (take_beat) begin
      o_buf_addr <= wr_ptr;
      o_buf_data <= i_cpl_data;
    end
  end

endmodule

// ==== rtl/ctrl_reg_decoder.sv ====
// Control register file and command decode
// Memory write payloads land in a register or raise command strobes
`timescale 1ns/1ps
`include "ingress_params.svh"

module ctrl_reg_decoder (
  input  logic                  clk,
  input  logic                  rst,
  input  logic                  i_reg_stb,
  input  logic [`DW_W-1:0]      i_reg_data,
  input  ingress_pkg::tlp_dw2_u i_hdr_dw2,
  input  logic [`DW_W-1:0]      i_control_addr_base,
  output logic [`DW_W-1:0]      o_write_a_addr,
  output logic [`DW_W-1:0]      o_write_b_addr,
  output logic [`DW_W-1:0]      o_read_a_addr,
  output logic [`DW_W-1:0]      o_read_b_addr,
  output logic [`DW_W-1:0]      o_status_addr,
  output logic [`DW_W-1:0]      o_buffer_size,
  output logic [`DW_W-1:0]      o_dev_addr,
  output logic [`DW_W-1:0]      o_ping_value,
  output logic [1:0]            o_update_buf,
  output logic                  o_update_buf_stb,
  output logic                  o_reg_write_stb,
  output logic                  o_cmd_rst_stb,
  output logic                  o_cmd_wr_stb,
  output logic                  o_cmd_rd_stb,
  output logic                  o_cmd_ping_stb,
  output logic                  o_cmd_rd_cfg_stb,
  output logic                  o_cmd_unknown_stb,
  output logic                  o_cmd_flg_fifo_stb,
  output logic                  o_cmd_flg_sel_per_stb,
  output logic                  o_cmd_flg_sel_mem_stb,
  output logic                  o_cmd_flg_sel_dma_stb,
  output logic [`DW_W-1:0]      o_cmd_data_count
);

  logic [`DW_W-1:0] wr_addr;
  logic [`DW_W-1:0] reg_idx;
  logic             is_cmd;

  // Byte address of the write, then dword index from the control base
  assign wr_addr = {i_hdr_dw2.mem_addr.dw_addr, 2'b00};
  assign reg_idx = (wr_addr - i_control_addr_base) >> 2;
  assign is_cmd  = reg_idx >= `REG_CMD_OFFSET;

  always_ff @(posedge clk) begin
    o_update_buf_stb      <= 1'b0;
    o_reg_write_stb       <= 1'b0;
    o_cmd_rst_stb         <= 1'b0;
    o_cmd_wr_stb          <= 1'b0;
    o_cmd_rd_stb          <= 1'b0;
    o_cmd_ping_stb        <= 1'b0;
    o_cmd_rd_cfg_stb      <= 1'b0;
    o_cmd_unknown_stb     <= 1'b0;
    o_cmd_flg_fifo_stb    <= 1'b0;
    o_cmd_flg_sel_per_stb <= 1'b0;
    o_cmd_flg_sel_mem_stb <= 1'b0;
    o_cmd_flg_sel_dma_stb <= 1'b0;
    if (rst) begin
      o_write_a_addr   <= '0;
      o_write_b_addr   <= '0;
      o_read_a_addr    <= '0;
      o_read_b_addr    <= '0;
      o_status_addr    <= '0;
      o_buffer_size    <= '0;
      o_dev_addr       <= '0;
      o_ping_value     <= '0;
      o_update_buf     <= 2'b00;
      o_cmd_data_count <= '0;
    end else if (i_reg_stb && is_cmd) begin
      o_cmd_data_count <= i_reg_data;
      case (reg_idx)
        `CMD_RESET: o_cmd_rst_stb <= 1'b1;
        `CMD_PER_WRITE, `CMD_PER_WRITE_FIFO: begin
          o_cmd_flg_sel_per_stb <= 1'b1;
          o_cmd_wr_stb          <= 1'b1;
          o_cmd_flg_fifo_stb    <= (reg_idx == `CMD_PER_WRITE_FIFO);
        end
        `CMD_PER_READ, `CMD_PER_READ_FIFO: begin
          o_cmd_flg_sel_per_stb <= 1'b1;
          o_cmd_rd_stb          <= 1'b1;
          o_cmd_flg_fifo_stb    <= (reg_idx == `CMD_PER_READ_FIFO);
        end
        `CMD_MEM_WRITE, `CMD_MEM_READ: begin
          o_cmd_flg_sel_mem_stb <= 1'b1;
          o_cmd_wr_stb          <= (reg_idx == `CMD_MEM_WRITE);
          o_cmd_rd_stb          <= (reg_idx == `CMD_MEM_READ);
        end
        `CMD_DMA_WRITE, `CMD_DMA_READ: begin
          o_cmd_flg_sel_dma_stb <= 1'b1;
          o_cmd_wr_stb          <= (reg_idx == `CMD_DMA_WRITE);
          o_cmd_rd_stb          <= (reg_idx == `CMD_DMA_READ);
        end
        `CMD_PING: begin
          o_cmd_ping_stb <= 1'b1;
          o_ping_value   <= i_reg_data;
        end
        `CMD_READ_CONFIG: o_cmd_rd_cfg_stb <= 1'b1;
        default: o_cmd_unknown_stb <= 1'b1;
      endcase
    end else if (i_reg_stb) begin
      o_reg_write_stb <= 1'b1;
      case (reg_idx)
        `REG_STATUS_BUF_ADDR: o_status_addr <= i_reg_data;
        `REG_BUFFER_READY: begin
          // Low two bits select which buffer is ready
          o_update_buf     <= i_reg_data[1:0];
          o_update_buf_stb <= 1'b1;
        end
        `REG_WRITE_BUF_A_ADDR: o_write_a_addr <= i_reg_data;
        `REG_WRITE_BUF_B_ADDR: o_write_b_addr <= i_reg_data;
        `REG_READ_BUF_A_ADDR:  o_read_a_addr  <= i_reg_data;
        `REG_READ_BUF_B_ADDR:  o_read_b_addr  <= i_reg_data;
        `REG_BUFFER_SIZE:      o_buffer_size  <= i_reg_data;
        `REG_DEV_ADDR:         o_dev_addr     <= i_reg_data;
        default: o_reg_write_stb <= 1'b1;
      endcase
    end
  end

endmodule

// ==== rtl/ingress_params.svh ====
// Ingress parser constants
// TLP header field positions, type codes, register map and widths
`ifndef INGRESS_PARAMS_SVH
`define INGRESS_PARAMS_SVH

`define DW_W 32

// Dword 0 fields
`define TLP_FMT_HI 30
`define TLP_FMT_LO 29
`define TLP_TYPE_HI 28
`define TLP_TYPE_LO 24
`define TLP_LEN_HI 9
`define TLP_LEN_LO 0
`define TLP_FMT_4DW_BIT 29

// Type codes whose with-data variant is told by the upper format bit
`define TLP_TYPE_MEM 5'b00000
`define TLP_TYPE_CPL 5'b01010

// Dword 1 of a completion
`define CPL_BYTE_CNT_HI 11
`define CPL_BYTE_CNT_LO 0

// Register indexes from the control base
`define REG_STATUS_BUF_ADDR 0
`define REG_BUFFER_READY 1
`define REG_WRITE_BUF_A_ADDR 2
`define REG_WRITE_BUF_B_ADDR 3
`define REG_READ_BUF_A_ADDR 4
`define REG_READ_BUF_B_ADDR 5
`define REG_BUFFER_SIZE 6
`define REG_DEV_ADDR 7

// Command indexes
`define REG_CMD_OFFSET 16
`define CMD_RESET 16
`define CMD_PER_WRITE 17
`define CMD_PER_WRITE_FIFO 18
`define CMD_PER_READ 19
`define CMD_PER_READ_FIFO 20
`define CMD_MEM_WRITE 21
`define CMD_MEM_READ 22
`define CMD_DMA_WRITE 23
`define CMD_DMA_READ 24
`define CMD_PING 25
`define CMD_READ_CONFIG 26

`define BUF_ADDR_W 11
`define BUF_OFFSET_W 13

`endif

// ==== rtl/ingress_pkg.sv ====
// Shared types for the ingress parser
// Header dword 2 is read as an address or as completion fields

package ingress_pkg;

  // Dword 2 of a 3-dword header, decoded by TLP type
  typedef union packed {
    // Memory request address, dword aligned
    struct packed {
      logic [29:0] dw_addr;
      logic [1:0]  rsvd;
    } mem_addr;
    // Completion requester, tag and lower address
    struct packed {
      logic [15:0] req_id;
      logic [7:0]  tag;
      logic        rsvd;
      logic [6:0]  lwr_addr;
    } cpl;
  } tlp_dw2_u;

endpackage

// ==== rtl/pcie_ingress.sv ====
// PCIe host-to-device ingress parser
// Stream control feeding the register decoder and the completion buffer writer
`timescale 1ns/1ps
`include "ingress_params.svh"

module pcie_ingress (
  input  logic                     clk,
  input  logic                     rst,
  // AXI stream from the host
  output logic                     o_axi_ingress_ready,
  input  logic [`DW_W-1:0]         i_axi_ingress_data,
  input  logic                     i_axi_ingress_last,
  input  logic                     i_axi_ingress_valid,
  input  logic [`DW_W-1:0]         i_control_addr_base,
  input  logic [`BUF_OFFSET_W-1:0] i_buf_offset,
  // Control registers
  output logic [`DW_W-1:0]         o_write_a_addr,
  output logic [`DW_W-1:0]         o_write_b_addr,
  output logic [`DW_W-1:0]         o_read_a_addr,
  output logic [`DW_W-1:0]         o_read_b_addr,
  output logic [`DW_W-1:0]         o_status_addr,
  output logic [`DW_W-1:0]         o_buffer_size,
  output logic [`DW_W-1:0]         o_dev_addr,
  output logic [`DW_W-1:0]         o_ping_value,
  output logic [1:0]               o_update_buf,
  output logic                     o_update_buf_stb,
  output logic                     o_reg_write_stb,
  // Commands
  output logic                     o_cmd_rst_stb,
  output logic                     o_cmd_wr_stb,
  output logic                     o_cmd_rd_stb,
  output logic                     o_cmd_ping_stb,
  output logic                     o_cmd_rd_cfg_stb,
  output logic                     o_cmd_unknown_stb,
  output logic                     o_cmd_flg_fifo_stb,
  output logic                     o_cmd_flg_sel_per_stb,
  output logic                     o_cmd_flg_sel_mem_stb,
  output logic                     o_cmd_flg_sel_dma_stb,
  output logic [`DW_W-1:0]         o_cmd_data_count,
  // Buffer write port and completion report
  output logic                     o_buf_we,
  output logic [`BUF_ADDR_W-1:0]   o_buf_addr,
  output logic [`DW_W-1:0]         o_buf_data,
  output logic                     o_cplt_pkt_stb,
  output logic [9:0]               o_cplt_pkt_cnt,
  output logic [7:0]               o_cplt_pkt_tag,
  output logic [11:0]              o_cplt_pkt_byte_count,
  output logic [6:0]               o_cplt_pkt_lwr_addr
);

  logic [`DW_W-1:0]      hdr_dw0;
  logic [`DW_W-1:0]      hdr_dw1;
  ingress_pkg::tlp_dw2_u hdr_dw2;
  logic                  reg_stb;
  logic [`DW_W-1:0]      reg_data;
  logic                  cpl_start;
  logic                  cpl_beat_stb;
  logic [`DW_W-1:0]      cpl_data;

  tlp_rx_ctrl u_rx_ctrl (
    .clk                 (clk),
    .rst                 (rst),
    .i_axi_ingress_data  (i_axi_ingress_data),
    .i_axi_ingress_last  (i_axi_ingress_last),
    .i_axi_ingress_valid (i_axi_ingress_valid),
    .o_axi_ingress_ready (o_axi_ingress_ready),
    .o_hdr_dw0           (hdr_dw0),
    .o_hdr_dw1           (hdr_dw1),
    .o_hdr_dw2           (hdr_dw2),
    .o_reg_stb           (reg_stb),
    .o_reg_data          (reg_data),
    .o_cpl_start         (cpl_start),
    .o_cpl_beat_stb      (cpl_beat_stb),
    .o_cpl_data          (cpl_data)
  );

  ctrl_reg_decoder u_reg_decoder (
    .clk                   (clk),
    .rst                   (rst),
    .i_reg_stb             (reg_stb),
    .i_reg_data            (reg_data),
    .i_hdr_dw2             (hdr_dw2),
    .i_control_addr_base   (i_control_addr_base),
    .o_write_a_addr        (o_write_a_addr),
    .o_write_b_addr        (o_write_b_addr),
    .o_read_a_addr         (o_read_a_addr),
    .o_read_b_addr         (o_read_b_addr),
    .o_status_addr         (o_status_addr),
    .o_buffer_size         (o_buffer_size),
    .o_dev_addr            (o_dev_addr),
    .o_ping_value          (o_ping_value),
    .o_update_buf          (o_update_buf),
    .o_update_buf_stb      (o_update_buf_stb),
    .o_reg_write_stb       (o_reg_write_stb),
    .o_cmd_rst_stb         (o_cmd_rst_stb),
    .o_cmd_wr_stb          (o_cmd_wr_stb),
    .o_cmd_rd_stb          (o_cmd_rd_stb),
    .o_cmd_ping_stb        (o_cmd_ping_stb),
    .o_cmd_rd_cfg_stb      (o_cmd_rd_cfg_stb),
    .o_cmd_unknown_stb     (o_cmd_unknown_stb),
    .o_cmd_flg_fifo_stb    (o_cmd_flg_fifo_stb),
    .o_cmd_flg_sel_per_stb (o_cmd_flg_sel_per_stb),
    .o_cmd_flg_sel_mem_stb (o_cmd_flg_sel_mem_stb),
    .o_cmd_flg_sel_dma_stb (o_cmd_flg_sel_dma_stb),
    .o_cmd_data_count      (o_cmd_data_count)
  );

  cpl_buffer_writer u_cpl_writer (
    .clk                   (clk),
    .rst                   (rst),
    .i_cpl_start           (cpl_start),
    .i_cpl_beat_stb        (cpl_beat_stb),
    .i_cpl_data            (cpl_data),
    .i_hdr_dw0             (hdr_dw0),
    .i_hdr_dw1             (hdr_dw1),
    .i_hdr_dw2             (hdr_dw2),
    .i_buf_offset          (i_buf_offset),
    .o_buf_we              (o_buf_we),
    .o_buf_addr            (o_buf_addr),
    .o_buf_data            (o_buf_data),
    .o_cplt_pkt_stb        (o_cplt_pkt_stb),
    .o_cplt_pkt_cnt        (o_cplt_pkt_cnt),
    .o_cplt_pkt_tag        (o_cplt_pkt_tag),
    .o_cplt_pkt_byte_count (o_cplt_pkt_byte_count),
    .o_cplt_pkt_lwr_addr   (o_cplt_pkt_lwr_addr)
  );

endmodule

// ==== rtl/tlp_rx_ctrl.sv ====
// TLP ingress control
// Accepts stream beats, captures the 3-dword header and routes the payload
`timescale 1ns/1ps
`include "ingress_params.svh"

module tlp_rx_ctrl (
  input  logic                  clk,
  input  logic                  rst,
  input  logic [`DW_W-1:0]      i_axi_ingress_data,
  input  logic                  i_axi_ingress_last,
  input  logic                  i_axi_ingress_valid,
  output logic                  o_axi_ingress_ready,
  output logic [`DW_W-1:0]      o_hdr_dw0,
  output logic [`DW_W-1:0]      o_hdr_dw1,
  output ingress_pkg::tlp_dw2_u o_hdr_dw2,
  output logic                  o_reg_stb,
  output logic [`DW_W-1:0]      o_reg_data,
  output logic                  o_cpl_start,
  output logic                  o_cpl_beat_stb,
  output logic [`DW_W-1:0]      o_cpl_data
);

  localparam logic [2:0] ST_IDLE     = 3'd0;
  localparam logic [2:0] ST_HDR      = 3'd1;
  localparam logic [2:0] ST_REG_WR   = 3'd2;
  localparam logic [2:0] ST_CPL_DATA = 3'd3;
  localparam logic [2:0] ST_FLUSH    = 3'd4;

  logic [2:0] state;
  logic [1:0] hdr_idx;
  logic       beat;
  logic       hdr_done;
  logic [1:0] fmt;
  logic [4:0] tlp_type;
  logic       data_3dw;
  logic       mwr_3dw;
  logic       cpld_3dw;

  assign beat     = i_axi_ingress_valid && o_axi_ingress_ready;
  assign hdr_done = beat && (state == ST_HDR) && (hdr_idx == 2'd2);

  // Dword 0 is already captured when the third header dword arrives
  assign fmt      = o_hdr_dw0[`TLP_FMT_HI:`TLP_FMT_LO];
  assign tlp_type = o_hdr_dw0[`TLP_TYPE_HI:`TLP_TYPE_LO];
  // Upper format bit marks a payload
  assign data_3dw = fmt[1] && !o_hdr_dw0[`TLP_FMT_4DW_BIT];
  assign mwr_3dw  = data_3dw && (tlp_type == `TLP_TYPE_MEM);
  assign cpld_3dw = data_3dw && (tlp_type == `TLP_TYPE_CPL);

  always_ff @(posedge clk) begin
    if (rst) begin
      state               <= ST_IDLE;
      hdr_idx             <= 2'd0;
      o_axi_ingress_ready <= 1'b0;
    end else if (beat && i_axi_ingress_last) begin
      // End of packet from any state
      o_axi_ingress_ready <= 1'b0;
      state               <= ST_IDLE;
    end else begin
      case (state)
        ST_IDLE: begin
          hdr_idx <= 2'd0;
          if (i_axi_ingress_valid) begin
            o_axi_ingress_ready <= 1'b1;
            state               <= ST_HDR;
          end
        end
        ST_HDR: begin
          if (beat) begin
            hdr_idx <= hdr_idx + 2'd1;
          end
          if (hdr_done) begin
            if (mwr_3dw) begin
              state <= ST_REG_WR;
            end else if (cpld_3dw) begin
              state <= ST_CPL_DATA;
            end else begin
              // 4-dword headers and other types
              state <= ST_FLUSH;
            end
          end
        end
        ST_REG_WR: begin
          // Only the first payload dword is a register value
          if (beat) begin
            state <= ST_FLUSH;
          end
        end
        ST_CPL_DATA: begin
          state <= ST_CPL_DATA;
        end
        default: begin
          state <= ST_FLUSH;
        end
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      o_reg_stb      <= 1'b0;
      o_cpl_start    <= 1'b0;
      o_cpl_beat_stb <= 1'b0;
    end else begin
      o_reg_stb      <= beat && (state == ST_REG_WR);
      o_cpl_start    <= hdr_done && cpld_3dw && !i_axi_ingress_last;
      o_cpl_beat_stb <= beat && (state == ST_CPL_DATA);
    end
  end

  // Header and payload capture
  always_ff @(posedge clk) begin
    if (beat && (state == ST_HDR)) begin
      case (hdr_idx)
        2'd0:    o_hdr_dw0 <= i_axi_ingress_data;
        2'd1:    o_hdr_dw1 <= i_axi_ingress_data;
        default: o_hdr_dw2 <= i_axi_ingress_data;
      endcase
    end
    if (beat && (state == ST_REG_WR)) begin
      o_reg_data <= i_axi_ingress_data;
    end
    if (beat && (state == ST_CPL_DATA)) begin
      o_cpl_data <= i_axi_ingress_data;
    end
  end

endmodule

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Build and run the ingress parser testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing \
  -f filelist.f \
  --top-module tb_pcie_ingress \
  --Mdir obj_dir \
  -o sim_tb

./obj_dir/sim_tb > sim.log 2>&1 || true
cat sim.log

if grep -q "\*\* FAIL \*\*" sim.log; then
  echo "simulation failed"
  exit 1
fi
echo "simulation finished without failure"

// ==== test/tlp_tasks.svh ====
// Testbench helpers for the ingress parser
// Beat and packet drivers on the AXI stream and result compare tasks
`ifndef TLP_TASKS_SVH
`define TLP_TASKS_SVH

task automatic check_word(input string name, input logic [`DW_W-1:0] got,
                          input logic [`DW_W-1:0] exp);
  if (got !== exp) begin
    errors++;
    $display("ERROR t=%0t %s got 0x%08h expected 0x%08h", $time, name, got, exp);
  end
endtask

task automatic check_strobe(input string name, input logic got, input logic exp);
  if (got !== exp) begin
    errors++;
    $display("ERROR t=%0t %s got %b expected %b", $time, name, got, exp);
  end
endtask

task automatic check_dw2(input string name, input ingress_pkg::tlp_dw2_u got,
                         input ingress_pkg::tlp_dw2_u exp);
  if (got !== exp) begin
    errors++;
    $display("ERROR t=%0t %s got 0x%08h expected 0x%08h", $time, name, got, exp);
  end
endtask

task automatic abort_run(input string what);
  $display("timeout while waiting for %s", what);
  $display("** FAIL **");
  $finish;
endtask

// Called on a rising edge and returns on the edge that accepts the beat
task automatic send_beat(input logic [`DW_W-1:0] data, input logic last);
  int gap;
  int waited;
  gap = $urandom % 3;
  repeat (gap) begin
    axi_valid <= 1'b0;
    @(posedge clk);
  end
  axi_valid <= 1'b1;
  axi_data  <= data;
  axi_last  <= last;
  waited = 0;
  do begin
    @(posedge clk);
    waited++;
  end while (!o_axi_ingress_ready && waited < 50);
  if (!o_axi_ingress_ready) begin
    abort_run("stream ready");
  end
endtask

task automatic end_packet();
  axi_valid <= 1'b0;
  axi_last  <= 1'b0;
endtask

`endif

// ==== test/tb_pcie_ingress.sv ====
// Testbench for the PCIe ingress parser
// Register writes, commands, completions and flushed packets with random valid gaps
`timescale 1ns/1ps
`include "ingress_params.svh"

module tb_pcie_ingress;

  localparam logic [`DW_W-1:0] CTRL_BASE = 32'h0001_0000;
  localparam logic [`BUF_OFFSET_W-1:0] BUF_OFF = 13'h0200;

  logic clk = 1'b0;
  logic rst = 1'b1;
  logic axi_valid = 1'b0;
  logic axi_last = 1'b0;
  logic [`DW_W-1:0] axi_data = '0;
  logic o_axi_ingress_ready, o_update_buf_stb, o_reg_write_stb, o_buf_we, o_cplt_pkt_stb;
  logic o_cmd_rst_stb, o_cmd_wr_stb, o_cmd_rd_stb, o_cmd_ping_stb, o_cmd_rd_cfg_stb;
  logic o_cmd_unknown_stb, o_cmd_flg_fifo_stb, o_cmd_flg_sel_per_stb;
  logic o_cmd_flg_sel_mem_stb, o_cmd_flg_sel_dma_stb;
  logic [`DW_W-1:0] o_write_a_addr, o_write_b_addr, o_read_a_addr, o_read_b_addr;
  logic [`DW_W-1:0] o_status_addr, o_buffer_size, o_dev_addr, o_ping_value;
  logic [`DW_W-1:0] o_cmd_data_count, o_buf_data;
  logic [1:0] o_update_buf;
  logic [`BUF_ADDR_W-1:0] o_buf_addr;
  logic [9:0] o_cplt_pkt_cnt;
  logic [7:0] o_cplt_pkt_tag;
  logic [11:0] o_cplt_pkt_byte_count;
  logic [6:0] o_cplt_pkt_lwr_addr;

  int errors = 0;
  int tests = 0;
  int failed_tests = 0;
  int buf_writes = 0;
  int stb_cnt[13];
  logic [12:0] stb_vec;
  logic [`BUF_ADDR_W+`DW_W-1:0] exp_buf_q[$];
  logic [`BUF_ADDR_W+`DW_W-1:0] exp_entry;
  logic [`DW_W-1:0] payload_q[$];
  logic [`DW_W-1:0] shadow[8];
  string stb_names[13] = '{"o_reg_write_stb", "o_update_buf_stb", "o_cmd_rst_stb",
    "o_cmd_wr_stb", "o_cmd_rd_stb", "o_cmd_ping_stb", "o_cmd_rd_cfg_stb",
    "o_cmd_unknown_stb", "o_cmd_flg_fifo_stb", "o_cmd_flg_sel_per_stb",
    "o_cmd_flg_sel_mem_stb", "o_cmd_flg_sel_dma_stb", "o_cplt_pkt_stb"};

  always #2 clk = ~clk;

  pcie_ingress UUT (.*, .i_axi_ingress_data(axi_data), .i_axi_ingress_last(axi_last),
    .i_axi_ingress_valid(axi_valid), .i_control_addr_base(CTRL_BASE), .i_buf_offset(BUF_OFF));

  assign stb_vec = {o_cplt_pkt_stb, o_cmd_flg_sel_dma_stb, o_cmd_flg_sel_mem_stb,
    o_cmd_flg_sel_per_stb, o_cmd_flg_fifo_stb, o_cmd_unknown_stb, o_cmd_rd_cfg_stb,
    o_cmd_ping_stb, o_cmd_rd_stb, o_cmd_wr_stb, o_cmd_rst_stb, o_update_buf_stb,
    o_reg_write_stb};

  `include "tlp_tasks.svh"

  function automatic int expected_reg_index(input logic [`DW_W-1:0] addr,
                                            input logic [`DW_W-1:0] base);
    return int'((addr - base) / 4);
  endfunction

  function automatic logic [`BUF_ADDR_W-1:0] expected_buf_addr(
      input logic [`BUF_OFFSET_W-1:0] offset, input logic [6:0] lwr, input int i);
    return `BUF_ADDR_W'(int'(offset) - int'(lwr) + i);
  endfunction

  // Strobe vector expected from the command map in stb_vec bit order
  function automatic logic [12:0] expected_cmd_strobes(input int idx);
    case (idx)
      `CMD_RESET:          return 13'h0004;
      `CMD_PER_WRITE:      return 13'h0208;
      `CMD_PER_WRITE_FIFO: return 13'h0308;
      `CMD_PER_READ:       return 13'h0210;
      `CMD_PER_READ_FIFO:  return 13'h0310;
      `CMD_MEM_WRITE:      return 13'h0408;
      `CMD_MEM_READ:       return 13'h0410;
      `CMD_DMA_WRITE:      return 13'h0808;
      `CMD_DMA_READ:       return 13'h0810;
      `CMD_PING:           return 13'h0020;
      `CMD_READ_CONFIG:    return 13'h0040;
      default:             return 13'h0080;
    endcase
  endfunction

  function automatic logic [`DW_W-1:0] reg_value(input int idx);
    logic [`DW_W-1:0] regs[8];
    regs = '{o_status_addr, {30'd0, o_update_buf}, o_write_a_addr, o_write_b_addr,
             o_read_a_addr, o_read_b_addr, o_buffer_size, o_dev_addr};
    return regs[idx];
  endfunction

  // Monitor of strobes and buffer writes
  always @(posedge clk) begin
    if (!rst) begin
      for (int i = 0; i < 13; i++) begin
        if (stb_vec[i]) stb_cnt[i]++;
      end
      if (o_buf_we) begin
        buf_writes++;
        if (exp_buf_q.size() == 0) begin
          errors++;
          $display("buffer write at %0t that no completion asked for", $time);
        end else begin
          exp_entry = exp_buf_q.pop_front();
          check_word("o_buf_addr", {21'd0, o_buf_addr}, {21'd0, exp_entry[42:32]});
          check_word("o_buf_data", o_buf_data, exp_entry[31:0]);
        end
      end
    end
  end

  task automatic clear_counts();
    @(negedge clk);
    foreach (stb_cnt[i]) stb_cnt[i] = 0;
    buf_writes = 0;
  endtask

  task automatic wait_strobe(input int idx);
    int waited;
    waited = 0;
    while (stb_cnt[idx] == 0 && waited < 200) begin
      @(negedge clk);
      waited++;
    end
    if (stb_cnt[idx] == 0) begin
      abort_run(stb_names[idx]);
    end else begin
      repeat (3) @(negedge clk);
    end
  endtask

  task automatic check_strobes(input logic [12:0] exp);
    for (int i = 0; i < 13; i++) check_strobe(stb_names[i], stb_cnt[i] != 0, exp[i]);
  endtask

  task automatic close_test(input string name, input int errs_before);
    tests++;
    if (errors != errs_before) failed_tests++;
    $display("test %-16s %s", name, (errors == errs_before) ? "passed" : "failed");
  endtask

  task automatic send_mem_write(input logic [`DW_W-1:0] addr, input logic [`DW_W-1:0] data);
    @(posedge clk);
    send_beat(32'h4000_0001, 1'b0);
    send_beat(32'h0000_000f, 1'b0);
    send_beat(addr, 1'b0);
    send_beat(data, 1'b1);
    end_packet();
  endtask

  task automatic reg_write_test(input logic [`DW_W-1:0] addr, input logic [`DW_W-1:0] data);
    int ri;
    clear_counts();
    send_mem_write(addr, data);
    ri = expected_reg_index(addr, CTRL_BASE);
    shadow[ri] = (ri == `REG_BUFFER_READY) ? {30'd0, data[1:0]} : data;
    wait_strobe(0);
    for (int i = 0; i < 8; i++) check_word($sformatf("register %0d", i), reg_value(i), shadow[i]);
    check_strobes({11'd0, ri == `REG_BUFFER_READY, 1'b1});
    check_dw2("hdr_dw2", UUT.hdr_dw2, addr);
  endtask

  initial begin
    int e;
    int n;
    logic [6:0] lwr;
    logic [7:0] tag;
    logic [12:0] exp;
    logic [`DW_W-1:0] data;
    logic [`DW_W-1:0] addr;
    void'($urandom(32'h1f01_764a));
    foreach (shadow[i]) shadow[i] = '0;
    foreach (stb_cnt[i]) stb_cnt[i] = 0;
    repeat (2) @(posedge clk);
    rst <= 1'b0;
    // Reset state
    e = errors;
    @(negedge clk);
    check_strobe("o_axi_ingress_ready", o_axi_ingress_ready, 1'b0);
    check_strobe("o_buf_we", o_buf_we, 1'b0);
    for (int i = 0; i < 13; i++) check_strobe(stb_names[i], stb_vec[i], 1'b0);
    for (int i = 0; i < 8; i++) check_word($sformatf("register %0d", i), reg_value(i), '0);
    check_word("o_ping_value", o_ping_value, '0);
    check_word("o_cmd_data_count", o_cmd_data_count, '0);
    close_test("reset", e);
    // Register writes
    e = errors;
    for (int i = 0; i < 8; i++) reg_write_test(CTRL_BASE + 32'(i * 4), $urandom);
    close_test("register_writes", e);
    // Commands plus one unmapped index
    e = errors;
    for (int i = 16; i <= 27; i++) begin
      addr = CTRL_BASE + 32'(((i == 27) ? 30 : i) * 4);
      data = $urandom;
      exp = expected_cmd_strobes(expected_reg_index(addr, CTRL_BASE));
      clear_counts();
      send_mem_write(addr, data);
      for (int b = 0; b < 13; b++) begin
        if (exp[b]) begin
          wait_strobe(b);
          break;
        end
      end
      check_strobes(exp);
      check_word("o_cmd_data_count", o_cmd_data_count, data);
      if (i == `CMD_PING) check_word("o_ping_value", o_ping_value, data);
    end
    close_test("commands", e);
    // Completions with data
    e = errors;
    for (int k = 0; k < 3; k++) begin
      n = 1 + k * 3;
      lwr = 7'($urandom);
      tag = 8'($urandom);
      payload_q.delete();
      for (int i = 0; i < n; i++) begin
        payload_q.push_back($urandom);
        exp_buf_q.push_back({expected_buf_addr(BUF_OFF, lwr, i), payload_q[i]});
      end
      clear_counts();
      @(posedge clk);
      send_beat(32'h4a00_0000 | 32'(n), 1'b0);
      send_beat({16'h0100, 4'h0, 12'(n * 4)}, 1'b0);
      send_beat({16'h0000, tag, 1'b0, lwr}, 1'b0);
      for (int i = 0; i < n; i++) send_beat(payload_q[i], i == n - 1);
      end_packet();
      wait_strobe(12);
      check_word("completion count", stb_cnt[12], 1);
      check_word("buffer writes", buf_writes, n);
      check_word("o_cplt_pkt_cnt", {22'd0, o_cplt_pkt_cnt}, n);
      check_word("o_cplt_pkt_tag", {24'd0, o_cplt_pkt_tag}, {24'd0, tag});
      check_word("o_cplt_pkt_byte_count", {20'd0, o_cplt_pkt_byte_count}, n * 4);
      check_word("o_cplt_pkt_lwr_addr", {25'd0, o_cplt_pkt_lwr_addr}, {25'd0, lwr});
      check_dw2("hdr_dw2", UUT.hdr_dw2, {16'h0000, tag, 1'b0, lwr});
    end
    if (exp_buf_q.size() != 0) begin
      errors++;
      $display("%0d expected buffer writes never happened", exp_buf_q.size());
    end
    close_test("completions", e);
    // Memory read and 4-dword write are flushed
    e = errors;
    clear_counts();
    @(posedge clk);
    send_beat(32'h0000_0001, 1'b0);
    send_beat(32'h0000_000f, 1'b0);
    send_beat(CTRL_BASE + 32'd8, 1'b1);
    send_beat(32'h6000_0001, 1'b0);
    send_beat(32'h0000_000f, 1'b0);
    send_beat(32'h0000_0000, 1'b0);
    send_beat(CTRL_BASE + 32'd8, 1'b0);
    send_beat(32'hdead_beef, 1'b1);
    end_packet();
    repeat (6) @(negedge clk);
    check_strobes(13'd0);
    check_word("buffer writes", buf_writes, 0);
    reg_write_test(CTRL_BASE + 32'd8, 32'h1234_5678);
    close_test("flush", e);
    $display("tests %0d, failed %0d, errors %0d", tests, failed_tests, errors);
    if (errors == 0) begin
      $display("** PASS **");
    end else begin
      $display("** FAIL **");
    end
    $finish;
  end

endmodule
